/* eth_test_pkg.sv */
//----------------------------------------------------------------------
// shared constants, register map and state types for the ethernet
// frame test; imported by every design unit with a wildcard import
//----------------------------------------------------------------------
package eth_test_pkg;

    // datapath and bus widths
    localparam int DATA_W = 8;
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;
    localparam int CNT_W  = 16;
    localparam int LEN_W  = 8;

    // frame length limits, reset value of the length register
    localparam logic [LEN_W-1:0] MIN_FRAME_LEN = LEN_W'(2);
    localparam logic [LEN_W-1:0] FRAME_LEN_RST = LEN_W'(8);

    // led blink half period, short so it shows up in simulation
    localparam int LED_HALF_CYCLES = 16;
    localparam int LED_CNT_W       = $clog2(LED_HALF_CYCLES);

    // bit positions inside CTRL and STATUS
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_ERR_BIT   = 1;

    //------------------------------------------------------------------
    // register word addresses
    //------------------------------------------------------------------
    typedef enum logic [APB_AW-1:0] {
        ADDR_CTRL      = APB_AW'('h00),
        ADDR_FRAME_LEN = APB_AW'('h04),
        ADDR_TX_COUNT  = APB_AW'('h08),
        ADDR_RX_GOOD   = APB_AW'('h0C),
        ADDR_RX_BAD    = APB_AW'('h10),
        ADDR_STATUS    = APB_AW'('h14)
    } reg_addr_e;

    // generator fsm
    typedef enum logic [0:0] {IDLE, SEND} gen_state_e;

    // checker fsm; DROP holds an overlong frame until its eof
    typedef enum logic [1:0] {WAIT_SOF, IN_FRAME, DROP} chk_state_e;

endpackage

/* test_ctrl_if.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// control and status bundle between the register block, the frame
// generator and the frame checker
//----------------------------------------------------------------------
interface test_ctrl_if import eth_test_pkg::*; ();

    // driven by the register block
    logic [LEN_W-1:0] frame_len;
    logic             gen_start;
    logic             cnt_clear;

    // driven by the generator
    logic             gen_busy;
    logic [CNT_W-1:0] tx_count;

    // driven by the checker
    logic [CNT_W-1:0] rx_good_count;
    logic [CNT_W-1:0] rx_bad_count;
    logic             rx_err_pulse;

    modport regs (
        output frame_len, gen_start, cnt_clear,
        input  gen_busy, tx_count, rx_good_count, rx_bad_count, rx_err_pulse
    );

    modport gen (
        input  frame_len, gen_start, cnt_clear,
        output gen_busy, tx_count
    );

    modport chk (
        input  frame_len, cnt_clear,
        output rx_good_count, rx_bad_count, rx_err_pulse
    );

endinterface

/* frame_pattern_gen.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// test frame generator; one counting-pattern frame per start pulse,
// seeded from the frame sequence number
//----------------------------------------------------------------------
module frame_pattern_gen import eth_test_pkg::*; (
    input  logic              clk20_g,
    input  logic              rst_n_i,
    test_ctrl_if.gen          ctrl,
    output logic [DATA_W-1:0] tx_data_o,
    output logic              tx_valid_o,
    output logic              tx_sof_o,
    output logic              tx_eof_o
);

    gen_state_e        state;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  byte_cnt;
    logic [DATA_W-1:0] data_q;
    logic [CNT_W-1:0]  tx_cnt_q;
    logic              accept;
    logic              busy_q;
    logic              sof_q;
    logic              eof_q;

    // busy starts are dropped, only idle accepts one
    assign accept = (state == IDLE) & ctrl.gen_start;

    // fsm
    always_ff @(posedge clk20_g) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (eof_q) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // byte counter and pattern
    always_ff @(posedge clk20_g) begin
        if (accept) begin
            len_q    <= ctrl.frame_len;
            byte_cnt <= '0;
            // seed = sequence number of this frame
            data_q   <= ctrl.cnt_clear ? '0 : tx_cnt_q[DATA_W-1:0];
        end else if (state == SEND) begin
            byte_cnt <= byte_cnt + LEN_W'(1);
            data_q   <= data_q + DATA_W'(1);
        end
    end

    // frame markers and busy flag, registered
    always_ff @(posedge clk20_g) begin
        if (!rst_n_i) begin
            sof_q  <= 1'b0;
            eof_q  <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            sof_q <= accept;
            // eof set one byte ahead
            // len_q is never below 2, so the subtraction cannot wrap
            eof_q <= (state == SEND) & (byte_cnt == len_q - LEN_W'(2));
            if (accept) begin
                busy_q <= 1'b1;
            end else if (eof_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    // frames sent, bumped on the eof byte
    always_ff @(posedge clk20_g) begin
        if (!rst_n_i) begin
            tx_cnt_q <= '0;
        end else if (ctrl.cnt_clear) begin
            tx_cnt_q <= '0;
        end else if (tx_eof_o) begin
            tx_cnt_q <= tx_cnt_q + CNT_W'(1);
        end
    end

    // stream outputs
    assign tx_valid_o = (state == SEND);
    assign tx_data_o  = data_q;
    assign tx_sof_o   = sof_q;
    assign tx_eof_o   = eof_q;

    assign ctrl.gen_busy = busy_q;
    assign ctrl.tx_count = tx_cnt_q;

endmodule

/* frame_pattern_chk.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// receive frame checker; rates each frame against the counting
// pattern, frame_len and the mac fr_good flag
//----------------------------------------------------------------------
module frame_pattern_chk import eth_test_pkg::*; (
    input  logic              clk20_g,
    input  logic              rst_n_i,
    test_ctrl_if.chk          ctrl,
    input  logic [DATA_W-1:0] rx_data_i,
    input  logic              rx_valid_i,
    input  logic              rx_sof_i,
    input  logic              rx_eof_i,
    input  logic              rx_fr_good_i
);

    chk_state_e        state;
    logic [DATA_W-1:0] prev_byte;
    logic [LEN_W-1:0]  run_len;
    logic              mismatch;
    logic [CNT_W-1:0]  good_cnt_q;
    logic [CNT_W-1:0]  bad_cnt_q;
    logic              err_pulse_q;

    logic              in_frame;
    logic              new_frame;
    logic              track;
    logic              abort_old;
    logic              seq_err;
    logic [LEN_W:0]    len_next;
    logic              mism_next;
    logic              frame_end;
    logic              frame_ok;
    logic [1:0]        bad_inc;

    //------------------------------------------------------------------
    // per-byte evaluation
    //------------------------------------------------------------------
    assign in_frame  = (state != WAIT_SOF);
    assign new_frame = rx_valid_i & rx_sof_i;
    // bytes that extend a frame still being tracked
    assign track     = rx_valid_i & ~rx_sof_i & (state == IN_FRAME);
    // sof inside a frame kills the old one
    assign abort_old = new_frame & in_frame;
    assign seq_err   = (rx_data_i != prev_byte + DATA_W'(1));

    // one extra bit so a 256th byte cannot wrap back
    assign len_next  = new_frame ? (LEN_W+1)'(1) : {1'b0, run_len} + (LEN_W+1)'(1);
    assign mism_next = new_frame ? 1'b0 : (mismatch | seq_err);

    assign frame_end = rx_valid_i & rx_eof_i & (new_frame | in_frame);
    // DROP frames are already known to be bad
    assign frame_ok  = frame_end & ~mism_next & rx_fr_good_i
                     & (len_next == {1'b0, ctrl.frame_len})
                     & (new_frame | (state == IN_FRAME));

    assign bad_inc = 2'(abort_old) + 2'(frame_end & ~frame_ok);

    // fsm
    always_ff @(posedge clk20_g) begin
        if (!rst_n_i) begin
            state <= WAIT_SOF;
        end else if (frame_end) begin
            state <= WAIT_SOF;
        end else if (new_frame) begin
            state <= IN_FRAME;
        end else if (track && len_next > {1'b0, ctrl.frame_len}) begin
            // too long, stop tracking and wait for eof
            state <= DROP;
        end
    end

    // previous byte, running length, mismatch flag
    always_ff @(posedge clk20_g) begin
        if (new_frame || track) begin
            prev_byte <= rx_data_i;
            run_len   <= len_next[LEN_W-1:0];
            mismatch  <= mism_next;
        end
    end

    //------------------------------------------------------------------
    // frame counters, valid the cycle after eof
    //------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (!rst_n_i || ctrl.cnt_clear) begin
            good_cnt_q  <= '0;
            bad_cnt_q   <= '0;
            err_pulse_q <= 1'b0;
        end else begin
            good_cnt_q  <= good_cnt_q + CNT_W'(frame_ok);
            bad_cnt_q   <= bad_cnt_q + CNT_W'(bad_inc);
            err_pulse_q <= (bad_inc != 2'd0);
        end
    end

    assign ctrl.rx_good_count = good_cnt_q;
    assign ctrl.rx_bad_count  = bad_cnt_q;
    assign ctrl.rx_err_pulse  = err_pulse_q;

endmodule

/* test_status_regs.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// apb register block for the link test; start/clear pulses, frame
// length, counters readback, sticky error and debug led blinker
//----------------------------------------------------------------------
module test_status_regs import eth_test_pkg::*; (
    input  logic              clk20_g,
    input  logic              rst_n_i,
    test_ctrl_if.regs         ctrl,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic              test_err_o,
    output logic              dbg_led_o
);

    logic                 acc;
    logic                 wr_ok;
    logic                 ctrl_wr;
    logic                 addr_hit;
    logic                 addr_ro;
    logic [APB_DW-1:0]    rd_mux;
    logic [LEN_W-1:0]     wr_len;
    logic [LEN_W-1:0]     frame_len_q;
    logic                 err_q;
    logic [LED_CNT_W-1:0] led_cnt;
    logic                 blink_q;

    //------------------------------------------------------------------
    // apb decode, zero wait states
    //------------------------------------------------------------------
    assign acc = psel_i & penable_i;

    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b1;
        rd_mux   = '0;
        case (paddr_i)
            ADDR_CTRL: begin
                // pulse bits only, reads back zero
                addr_ro = 1'b0;
            end
            ADDR_FRAME_LEN: begin
                addr_ro = 1'b0;
                rd_mux  = APB_DW'(frame_len_q);
            end
            ADDR_TX_COUNT: begin
                rd_mux = APB_DW'(ctrl.tx_count);
            end
            ADDR_RX_GOOD: begin
                rd_mux = APB_DW'(ctrl.rx_good_count);
            end
            ADDR_RX_BAD: begin
                rd_mux = APB_DW'(ctrl.rx_bad_count);
            end
            ADDR_STATUS: begin
                rd_mux[STAT_BUSY_BIT] = ctrl.gen_busy;
                rd_mux[STAT_ERR_BIT]  = err_q;
            end
            default: begin
                addr_hit = 1'b0;
                addr_ro  = 1'b0;
            end
        endcase
    end

    // only mapped, writable registers take a write
    assign wr_ok   = acc & pwrite_i & addr_hit & ~addr_ro;
    assign ctrl_wr = wr_ok & (paddr_i == ADDR_CTRL);

    assign pready_o  = 1'b1;
    assign pslverr_o = acc & (~addr_hit | (pwrite_i & addr_ro));
    assign prdata_o  = (acc & ~pwrite_i) ? rd_mux : '0;

    // start and clear fire in the access phase itself
    assign ctrl.gen_start = ctrl_wr & pwdata_i[CTRL_START_BIT];
    assign ctrl.cnt_clear = ctrl_wr & pwdata_i[CTRL_CLEAR_BIT];

    //------------------------------------------------------------------
    // frame length, clamped to the legal minimum
    //------------------------------------------------------------------
    assign wr_len = (pwdata_i[LEN_W-1:0] < MIN_FRAME_LEN) ?
                    MIN_FRAME_LEN : pwdata_i[LEN_W-1:0];

    always_ff @(posedge clk20_g) begin
        if (!rst_n_i) begin
            frame_len_q <= FRAME_LEN_RST;
        end else if (wr_ok && paddr_i == ADDR_FRAME_LEN) begin
            frame_len_q <= wr_len;
        end
    end

    assign ctrl.frame_len = frame_len_q;

    // sticky error, cleared only by clear or reset
    always_ff @(posedge clk20_g) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else if (ctrl.cnt_clear) begin
            err_q <= 1'b0;
        end else if (ctrl.rx_err_pulse) begin
            err_q <= 1'b1;
        end
    end

    assign test_err_o = err_q;

    //------------------------------------------------------------------
    // led blinker
    //------------------------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (!rst_n_i) begin
            led_cnt <= '0;
            blink_q <= 1'b0;
        end else if (led_cnt == LED_CNT_W'(LED_HALF_CYCLES - 1)) begin
            led_cnt <= '0;
            blink_q <= ~blink_q;
        end else begin
            led_cnt <= led_cnt + LED_CNT_W'(1);
        end
    end

    // steady on after an error, blinking while the link is clean
    assign dbg_led_o = err_q | blink_q;

endmodule

/* eth_frame_test.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// ethernet link test top; pattern generator on tx, checker on rx,
// apb register block for control and status
//----------------------------------------------------------------------
module eth_frame_test import eth_test_pkg::*; (
    input  logic              clk20_g,
    input  logic              rst_n_i,
    // apb slave
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  logic [APB_AW-1:0] paddr_i,
    input  logic [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    // transmit stream
    output logic [DATA_W-1:0] tx_data_o,
    output logic              tx_valid_o,
    output logic              tx_sof_o,
    output logic              tx_eof_o,
    // receive stream
    input  logic [DATA_W-1:0] rx_data_i,
    input  logic              rx_valid_i,
    input  logic              rx_sof_i,
    input  logic              rx_eof_i,
    input  logic              rx_fr_good_i,
    // status
    output logic              test_err_o,
    output logic              dbg_led_o
);

    test_ctrl_if ctrl_if ();

    // tx side
    frame_pattern_gen gen0 (
        .clk20_g    (clk20_g),
        .rst_n_i    (rst_n_i),
        .ctrl       (ctrl_if.gen),
        .tx_data_o  (tx_data_o),
        .tx_valid_o (tx_valid_o),
        .tx_sof_o   (tx_sof_o),
        .tx_eof_o   (tx_eof_o)
    );

    // rx side
    frame_pattern_chk chk0 (
        .clk20_g      (clk20_g),
        .rst_n_i      (rst_n_i),
        .ctrl         (ctrl_if.chk),
        .rx_data_i    (rx_data_i),
        .rx_valid_i   (rx_valid_i),
        .rx_sof_i     (rx_sof_i),
        .rx_eof_i     (rx_eof_i),
        .rx_fr_good_i (rx_fr_good_i)
    );

    // registers and led
    test_status_regs regs0 (
        .clk20_g    (clk20_g),
        .rst_n_i    (rst_n_i),
        .ctrl       (ctrl_if.regs),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .test_err_o (test_err_o),
        .dbg_led_o  (dbg_led_o)
    );

endmodule

/* eth_frame_test_checker.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// stream and pulse assertions, bound into the generator and checker
//----------------------------------------------------------------------
module eth_frame_test_checker (
    input logic clk20_g,
    input logic rst_n_i,
    input logic valid_i,
    input logic sof_i,
    input logic eof_i,
    input logic busy_i,
    input logic err_pulse_i
);

    // frame markers only on valid bytes
    sof_eof_valid_a: assert property (@(posedge clk20_g) disable iff (!rst_n_i)
        (sof_i || eof_i) |-> valid_i)
        else $error("frame marker without valid");

    // no byte leaves an idle generator
    valid_busy_a: assert property (@(posedge clk20_g) disable iff (!rst_n_i)
        valid_i |-> busy_i)
        else $error("valid while generator not busy");

    // one cycle per bad frame
    err_pulse_a: assert property (@(posedge clk20_g) disable iff (!rst_n_i)
        err_pulse_i |=> !err_pulse_i)
        else $error("error pulse longer than one cycle");

endmodule

// tx side, no error pulse here
bind frame_pattern_gen eth_frame_test_checker gen_chk0 (
    .clk20_g     (clk20_g),
    .rst_n_i     (rst_n_i),
    .valid_i     (tx_valid_o),
    .sof_i       (tx_sof_o),
    .eof_i       (tx_eof_o),
    .busy_i      (ctrl.gen_busy),
    .err_pulse_i (1'b0)
);

// rx side, stream checks tied off
bind frame_pattern_chk eth_frame_test_checker chk_chk0 (
    .clk20_g     (clk20_g),
    .rst_n_i     (rst_n_i),
    .valid_i     (1'b0),
    .sof_i       (1'b0),
    .eof_i       (1'b0),
    .busy_i      (1'b0),
    .err_pulse_i (ctrl.rx_err_pulse)
);

/* tb_clk_gen.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// testbench clock and reset; 8 ns clock, reset low for 3 cycles
//----------------------------------------------------------------------
module tb_clk_gen (
    output logic clk20_g,
    output logic rst_n_o
);

    // 4 ns half period
    initial begin
        clk20_g = 1'b0;
        forever #4 clk20_g = ~clk20_g;
    end

    // synchronous reset, released just after the third edge
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk20_g);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

/* tb_eth_frame_test.sv */
`timescale 1ns/100ps
//----------------------------------------------------------------------
// testbench top; runs the operations of frame_test_input.txt against
// the link test, captures tx frames and checks registers and led
//----------------------------------------------------------------------
module tb_eth_frame_test import eth_test_pkg::*; ();

    logic        clk20_g;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic [7:0]  tx_data_o;
    logic        tx_valid_o;
    logic        tx_sof_o;
    logic        tx_eof_o;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_sof;
    logic        rx_eof;
    logic        rx_fr_good;
    logic        test_err_o;
    logic        dbg_led_o;

    // run bookkeeping
    int cyc = 0;
    int cyc_limit = 0;
    int check_cnt = 0;
    int mismatch_cnt = 0;
    int other_err = 0;
    int start_cyc = 0;
    bit start_pending = 1'b0;
    int exp_seq = 0;
    // tx scoreboard
    bit in_tx = 1'b0;
    int cur_len;
    int cur_first;
    int cur_prev;
    int cur_sof_cyc;
    int tx_len_q[$];
    int tx_first_q[$];
    int tx_sof_q[$];

    tb_clk_gen clk_gen0 (
        .clk20_g (clk20_g),
        .rst_n_o (rst_n)
    );

    eth_frame_test dut0 (
        .clk20_g      (clk20_g),
        .rst_n_i      (rst_n),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .tx_data_o    (tx_data_o),
        .tx_valid_o   (tx_valid_o),
        .tx_sof_o     (tx_sof_o),
        .tx_eof_o     (tx_eof_o),
        .rx_data_i    (rx_data),
        .rx_valid_i   (rx_valid),
        .rx_sof_i     (rx_sof),
        .rx_eof_i     (rx_eof),
        .rx_fr_good_i (rx_fr_good),
        .test_err_o   (test_err_o),
        .dbg_led_o    (dbg_led_o)
    );

    task automatic check_val(input string name, input int exp, input int act);
        check_cnt++;
        if (exp != act) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        end
    endtask

    //------------------------------------------------------------------
    // apb access, setup then access phase, sampled mid access
    //------------------------------------------------------------------
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output int rdata, output int err);
        @(posedge clk20_g);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk20_g);
        #1;
        penable = 1'b1;
        @(negedge clk20_g);
        rdata = prdata_o;
        err   = int'(pslverr_o);
        check_val("pready_o", 1, int'(pready_o));
        // first start since the last tx expectation
        if (wr && addr == ADDR_CTRL && wdata[CTRL_START_BIT] && !start_pending) begin
            start_cyc     = cyc;
            start_pending = 1'b1;
        end
        @(posedge clk20_g);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // loopback frame into rx, random idle gap first
    task automatic send_rx_frame(input int first, input int len, input int skip,
                                 input int good, input int no_eof);
        int gap;
        int k;
        int b;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk20_g);
        for (k = 0; k < len; k++) begin
            // skip adds one from that byte on
            b = first + k + ((skip != 0 && k >= skip) ? 1 : 0);
            @(posedge clk20_g);
            #1;
            rx_valid   = 1'b1;
            rx_data    = b[7:0];
            rx_sof     = (k == 0);
            rx_eof     = (k == len - 1) && (no_eof == 0);
            rx_fr_good = good[0];
        end
        @(posedge clk20_g);
        #1;
        rx_valid   = 1'b0;
        rx_sof     = 1'b0;
        rx_eof     = 1'b0;
        rx_fr_good = 1'b0;
    endtask

    // error flag and led: blinking when clear, steady on when set
    task automatic check_led(input int exp_err);
        int   n;
        logic last;
        repeat (2) @(posedge clk20_g);
        @(negedge clk20_g);
        check_val("test_err_o", exp_err, int'(test_err_o));
        n = 0;
        if (exp_err != 0) begin
            while (n < 2 * LED_HALF_CYCLES + 2 && dbg_led_o == 1'b1) begin
                @(negedge clk20_g);
                n++;
            end
            check_val("dbg_led_o high cycles", 2 * LED_HALF_CYCLES + 2, n);
        end else begin
            last = dbg_led_o;
            while (n <= 2 * LED_HALF_CYCLES && dbg_led_o == last) begin
                @(negedge clk20_g);
                n++;
            end
            if (dbg_led_o == last) begin
                other_err++;
                $display("dbg_led_o did not toggle while the error flag was clear");
            end else begin
                last = dbg_led_o;
                n    = 0;
                while (n <= 2 * LED_HALF_CYCLES && dbg_led_o == last) begin
                    @(negedge clk20_g);
                    n++;
                end
                check_val("dbg_led_o half period", LED_HALF_CYCLES, n);
            end
        end
    endtask

    //------------------------------------------------------------------
    // tx capture at negedge, pattern checked byte by byte
    //------------------------------------------------------------------
    always @(negedge clk20_g) begin
        if (rst_n && tx_valid_o) begin
            if (tx_sof_o) begin
                if (in_tx) begin
                    other_err++;
                    $display("tx start of frame inside a running frame at %0t", $time);
                end
                in_tx       = 1'b1;
                cur_len     = 1;
                cur_first   = int'(tx_data_o);
                cur_prev    = cur_first;
                cur_sof_cyc = cyc;
            end else if (in_tx) begin
                check_val("tx_data_o", (cur_prev + 1) % 256, int'(tx_data_o));
                cur_prev = int'(tx_data_o);
                cur_len++;
            end else begin
                other_err++;
                $display("tx byte outside a frame at %0t", $time);
            end
            if (tx_eof_o && in_tx) begin
                tx_len_q.push_back(cur_len);
                tx_first_q.push_back(cur_first);
                tx_sof_q.push_back(cur_sof_cyc);
                in_tx = 1'b0;
            end
        end else if (rst_n && in_tx) begin
            other_err++;
            $display("tx_valid_o dropped inside a frame at %0t", $time);
            in_tx = 1'b0;
        end
    end

    // cycle count and watchdog
    always @(posedge clk20_g) begin
        cyc++;
        if (cyc_limit > 0 && cyc > cyc_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cyc_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int          fd;
        int          code;
        int          n_lines;
        int          a;
        int          d;
        int          e;
        int          f3;
        int          f4;
        int          rd;
        int          err;
        logic [7:0]  op;
        logic [1023:0] line_buf;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        rx_data    = '0;
        rx_valid   = 1'b0;
        rx_sof     = 1'b0;
        rx_eof     = 1'b0;
        rx_fr_good = 1'b0;
        void'($urandom(45));
        fd = $fopen("frame_test_input.txt", "r");
        if (fd == 0) begin
            other_err++;
            $display("cannot open frame_test_input.txt");
        end else begin
            // first pass counts operations for the cycle limit
            n_lines = 0;
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", op);
                if (code == 1) begin
                    void'($fgets(line_buf, fd));
                    if (op != "#") n_lines++;
                end
            end
            $fclose(fd);
            cyc_limit = n_lines * (255 + 20) + 200;
            fd = $fopen("frame_test_input.txt", "r");
            while (rst_n !== 1'b1) @(posedge clk20_g);
            @(negedge clk20_g);
            // outputs right after reset
            check_val("tx_valid_o", 0, int'(tx_valid_o));
            check_val("tx_sof_o", 0, int'(tx_sof_o));
            check_val("tx_eof_o", 0, int'(tx_eof_o));
            check_val("test_err_o", 0, int'(test_err_o));
            check_val("pslverr_o", 0, int'(pslverr_o));
            check_val("dbg_led_o", 0, int'(dbg_led_o));
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", op);
                if (code == 1) begin
                    case (op)
                        "#": begin
                            void'($fgets(line_buf, fd));
                        end
                        "W": begin
                            code = $fscanf(fd, "%h %h %h", a, d, e);
                            apb_access(1'b1, a[7:0], d, rd, err);
                            check_val("pslverr_o", e, err);
                            // clear also restarts the tx sequence
                            if (a[7:0] == ADDR_CTRL && d[CTRL_CLEAR_BIT]) exp_seq = 0;
                        end
                        "R": begin
                            code = $fscanf(fd, "%h %h %h", a, d, e);
                            apb_access(1'b0, a[7:0], 32'h0, rd, err);
                            check_val($sformatf("prdata_o@%02h", a[7:0]), d, rd);
                            check_val("pslverr_o", e, err);
                        end
                        "F": begin
                            code = $fscanf(fd, "%h %h %h %h %h", a, d, e, f3, f4);
                            send_rx_frame(a, d, e, f3, f4);
                        end
                        "T": begin
                            code = $fscanf(fd, "%h", a);
                            while (tx_len_q.size() == 0) @(negedge clk20_g);
                            check_val("tx frame length", a, tx_len_q.pop_front());
                            check_val("tx first byte", exp_seq % 256, tx_first_q.pop_front());
                            d = tx_sof_q.pop_front();
                            if (start_pending) begin
                                check_val("tx_valid_o delay", 1, d - start_cyc);
                            end else begin
                                other_err++;
                                $display("tx frame seen without a start write");
                            end
                            start_pending = 1'b0;
                            exp_seq++;
                        end
                        "L": begin
                            code = $fscanf(fd, "%h", a);
                            check_led(a);
                        end
                        default: begin
                            other_err++;
                            $display("unknown operation in data file");
                            void'($fgets(line_buf, fd));
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (tx_len_q.size() != 0) begin
                other_err++;
                $display("%0d tx frames arrived that were not expected", tx_len_q.size());
            end
        end
        $display("checks=%0d mismatches=%0d other_errors=%0d",
                 check_cnt, mismatch_cnt, other_err);
        if (mismatch_cnt == 0 && other_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* frame_test_input.txt */
# W addr data exp_pslverr | R addr exp_data exp_pslverr | T exp_len | L exp_err
# F first_byte len skip_at(0=none) fr_good no_eof ; all fields hex
# reset values and blinking
R 00 00000000 0
R 04 00000008 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 00000000 0
L 0
# 5-byte frame, the second start lands while busy
W 04 00000005 0
R 04 00000005 0
W 00 00000001 0
W 00 00000001 0
T 05
R 08 00000001 0
# length 1 is stored as 2
W 04 00000001 0
R 04 00000002 0
W 00 00000001 0
T 02
R 08 00000002 0
# good rx frames, second one wraps
W 04 00000008 0
F 10 08 00 1 0
F FE 08 00 1 0
R 0C 00000002 0
R 10 00000000 0
R 14 00000000 0
L 0
# skipped byte
F 20 08 03 1 0
L 1
R 10 00000001 0
R 14 00000002 0
# short, long, fr_good low, then sof inside a frame
F 30 07 00 1 0
F 38 09 00 1 0
F 48 08 00 0 0
F 50 04 00 1 1
F 60 08 00 1 0
R 0C 00000003 0
R 10 00000005 0
R 14 00000002 0
L 1
# clear
W 00 00000002 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 14 00000000 0
R 04 00000008 0
L 0
# frame after clear, busy seen in status
W 00 00000001 0
R 14 00000001 0
T 08
R 08 00000001 0
# slave errors
R 18 00000000 1
W 08 00000055 1
R 08 00000001 0
W 14 000000FF 1
R 14 00000000 0

/* src.f */
eth_test_pkg.sv
test_ctrl_if.sv
frame_pattern_gen.sv
frame_pattern_chk.sv
test_status_regs.sv
eth_frame_test.sv
eth_frame_test_checker.sv
tb_clk_gen.sv
tb_eth_frame_test.sv

/* run_sim.sh */
#!/bin/sh
# build and run the link test with verilator, non-zero exit on failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_eth_frame_test -f src.f -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error status"

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended early, see sim.log"; exit 1; }
echo "simulation passed"
